//--- hdl/icache_pkg.sv
package icache_pkg;

    // cache geometry, 16 sets of 4-word lines.
    localparam int INDEX_BITS  = 4;
    localparam int OFFSET_BITS = 2;
    localparam int LINE_WORDS  = 1 << OFFSET_BITS;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - 2;
    localparam int SETS        = 1 << INDEX_BITS;

    typedef logic [31:0] addr_t;

    // field view of an instruction address.
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
        logic [1:0]             byte_sel;  // always zero for word fetches.
    } addr_fields_t;

    typedef union packed {
        addr_t        raw;
        addr_fields_t f;
    } fetch_addr_u;

    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        fetch_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        addr_t       addr;
        logic [31:0] inst;
    } fetch_resp_t;

    typedef struct packed {
        addr_t base;  // line aligned.
    } refill_req_t;

endpackage

//--- hdl/icache_arrays.sv
`timescale 1ns/1ps

module icache_arrays import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_BITS-1:0] rd_index,
    output logic                  rd_valid,
    output logic [TAG_BITS-1:0]   rd_tag,
    output line_t                 rd_line,
    input  logic                  wr_en,
    input  logic [INDEX_BITS-1:0] wr_index,
    input  logic [TAG_BITS-1:0]   wr_tag,
    input  line_t                 wr_line,
    input  logic                  flush_all
);

    logic [SETS-1:0]     valid_q;
    logic [TAG_BITS-1:0] tag_mem [SETS];
    line_t               line_mem [SETS];

    always_ff @(posedge clk)
    begin
        if (rst || flush_all)
        begin
            valid_q <= '0;
        end
        else if (wr_en)
        begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= valid_q[rd_index];
        end
    end

    // tag and data stores, read returns the old contents on a same-index write.
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
        rd_tag  <= tag_mem[rd_index];
        rd_line <= line_mem[rd_index];
    end

endmodule

//--- hdl/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        refill_valid,
    input  refill_req_t refill_req,
    output logic        refill_ready,
    output logic        line_done,
    output line_t       line_data,
    output logic        mem_req_valid,
    output addr_t       mem_req_addr,
    input  logic        mem_ready,
    input  addr_t       mem_rdata
);

    logic                   busy_q;
    logic                   done_q;
    logic [OFFSET_BITS-1:0] beat_q;
    fetch_addr_u            base_q;
    line_t                  line_q;
    logic                   beat_fire;
    logic                   last_beat;

    assign refill_ready  = !busy_q;
    assign mem_req_valid = busy_q;
    assign mem_req_addr  = {base_q.f.tag, base_q.f.index, beat_q, 2'b00};  // ascending words.
    assign beat_fire     = mem_req_valid && mem_ready;
    assign last_beat     = beat_q == OFFSET_BITS'(LINE_WORDS - 1);
    assign line_done     = done_q;
    assign line_data     = line_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            beat_q <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (refill_valid && refill_ready)
            begin
                busy_q <= 1'b1;
                beat_q <= '0;
            end
            else if (beat_fire)
            begin
                beat_q <= beat_q + 1'b1;
                if (last_beat)
                begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;  // one cycle after the last word.
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_valid && refill_ready)
        begin
            base_q.raw <= refill_req.base;
        end
        if (beat_fire)
        begin
            line_q[beat_q] <= mem_rdata;
        end
    end

endmodule

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  fetch_req_t            req,
    output logic                  req_ready,
    output logic                  resp_valid,
    output fetch_resp_t           resp,
    input  logic                  flush,
    output logic [INDEX_BITS-1:0] rd_index,
    input  logic                  rd_valid,
    input  logic [TAG_BITS-1:0]   rd_tag,
    input  line_t                 rd_line,
    output logic                  wr_en,
    output logic [INDEX_BITS-1:0] wr_index,
    output logic [TAG_BITS-1:0]   wr_tag,
    output line_t                 wr_line,
    output logic                  flush_all,
    output logic                  refill_valid,
    output refill_req_t           refill_req,
    input  logic                  refill_ready,
    input  logic                  line_done,
    input  line_t                 line_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_COMPARE,
        S_REFILL,
        S_INSTALL
    } state_t;

    state_t      state;
    state_t      state_next;
    fetch_addr_u addr_q;
    line_t       line_q;
    logic        flush_pend;
    logic        flush_req;
    logic        hit;

    // a flush pulse is held until the FSM is back in idle.
    assign flush_req  = flush || flush_pend;
    assign flush_all  = (state == S_IDLE) && flush_req;
    assign hit        = rd_valid && (rd_tag == addr_q.f.tag);
    assign req_ready  = !flush_req && ((state == S_IDLE) || (state == S_COMPARE && hit));
    assign resp_valid = (state == S_COMPARE && hit) || (state == S_INSTALL);
    assign resp.addr  = addr_q.raw;
    assign resp.inst  = (state == S_INSTALL) ? line_q[addr_q.f.offset]
                                             : rd_line[addr_q.f.offset];

    assign rd_index        = addr_q.f.index;
    assign refill_valid    = (state == S_COMPARE) && !hit;
    assign refill_req.base = {addr_q.f.tag, addr_q.f.index, {OFFSET_BITS{1'b0}}, 2'b00};
    assign wr_en           = state == S_INSTALL;
    assign wr_index        = addr_q.f.index;
    assign wr_tag          = addr_q.f.tag;
    assign wr_line         = line_q;

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:    if (req_valid && req_ready) state_next = S_LOOKUP;
            S_LOOKUP:  state_next = S_COMPARE;  // array read in flight.
            S_COMPARE:
            begin
                if (hit)
                    state_next = (req_valid && req_ready) ? S_LOOKUP : S_IDLE;
                else if (refill_ready)
                    state_next = S_REFILL;
            end
            S_REFILL:  if (line_done) state_next = S_INSTALL;
            S_INSTALL: state_next = S_IDLE;
            default:   state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            flush_pend <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            flush_pend <= flush_req && !flush_all;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            addr_q <= req.addr;
        if (state == S_REFILL && line_done)
            line_q <= line_data;
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import icache_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  addr_t       redirect_pc,
    output logic        req_valid,
    output fetch_req_t  req,
    input  logic        req_ready,
    input  logic        resp_valid,
    input  fetch_resp_t resp,
    output logic        inst_valid,
    output fetch_resp_t inst_data,
    input  logic        inst_ready
);

    addr_t       pc;
    logic        epoch;
    logic        req_epoch;
    logic        inflight;
    logic        req_hold;
    logic        out_valid;
    logic        skid_valid;
    fetch_resp_t out_data;
    fetch_resp_t skid_data;
    logic        can_issue;
    logic        req_fire;
    logic        pop;
    logic        push;

    assign pop       = out_valid && inst_ready;
    assign push      = resp_valid && (req_epoch == epoch);  // stale answers are dropped.
    assign can_issue = !skid_valid && (!out_valid || inst_ready) && (!inflight || resp_valid);
    assign req_valid = req_hold || can_issue;
    assign req_fire  = req_valid && req_ready;
    assign req.addr.raw = pc;
    assign inst_valid   = out_valid;
    assign inst_data    = out_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc         <= RESET_PC;
            epoch      <= 1'b0;
            req_epoch  <= 1'b0;
            inflight   <= 1'b0;
            req_hold   <= 1'b0;
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else
        begin
            req_hold <= req_valid && !req_ready;  // keeps valid up until taken.
            if (req_fire)
            begin
                inflight  <= 1'b1;
                req_epoch <= epoch;
            end
            else if (resp_valid)
            begin
                inflight <= 1'b0;
            end

            if (redirect_valid)
            begin
                pc         <= redirect_pc;
                epoch      <= !epoch;
                out_valid  <= 1'b0;
                skid_valid <= 1'b0;
            end
            else
            begin
                if (req_fire)
                    pc <= pc + 32'd4;
                if (!out_valid || pop)
                begin
                    out_valid  <= skid_valid || push;
                    skid_valid <= skid_valid && push;
                end
                else if (push)
                begin
                    skid_valid <= 1'b1;  // output held, park the answer.
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!out_valid || pop)
            out_data <= skid_valid ? skid_data : resp;
        if (push)
            skid_data <= resp;
    end

endmodule

//--- hdl/ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top import icache_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  addr_t       redirect_pc,
    input  logic        flush,
    output logic        inst_valid,
    output fetch_resp_t inst_data,
    input  logic        inst_ready,
    output logic        mem_req_valid,
    output addr_t       mem_req_addr,
    input  logic        mem_ready,
    input  addr_t       mem_rdata
);

    logic                  req_valid;
    logic                  req_ready;
    fetch_req_t            req;
    logic                  resp_valid;
    fetch_resp_t           resp;
    logic [INDEX_BITS-1:0] rd_index;
    logic                  rd_valid;
    logic [TAG_BITS-1:0]   rd_tag;
    line_t                 rd_line;
    logic                  wr_en;
    logic [INDEX_BITS-1:0] wr_index;
    logic [TAG_BITS-1:0]   wr_tag;
    line_t                 wr_line;
    logic                  flush_all;
    logic                  refill_valid;
    logic                  refill_ready;
    refill_req_t           refill_req;
    logic                  line_done;
    line_t                 line_data;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp(resp),
        .inst_valid(inst_valid),
        .inst_data(inst_data),
        .inst_ready(inst_ready)
    );

    icache_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp(resp),
        .flush(flush),
        .rd_index(rd_index),
        .rd_valid(rd_valid),
        .rd_tag(rd_tag),
        .rd_line(rd_line),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_tag(wr_tag),
        .wr_line(wr_line),
        .flush_all(flush_all),
        .refill_valid(refill_valid),
        .refill_req(refill_req),
        .refill_ready(refill_ready),
        .line_done(line_done),
        .line_data(line_data)
    );

    icache_arrays u_arrays (
        .clk(clk),
        .rst(rst),
        .rd_index(rd_index),
        .rd_valid(rd_valid),
        .rd_tag(rd_tag),
        .rd_line(rd_line),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_tag(wr_tag),
        .wr_line(wr_line),
        .flush_all(flush_all)
    );

    icache_refill u_refill (
        .clk(clk),
        .rst(rst),
        .refill_valid(refill_valid),
        .refill_req(refill_req),
        .refill_ready(refill_ready),
        .line_done(line_done),
        .line_data(line_data),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] KEY = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic [31:0] req_addr,
    output logic        ready,
    output logic [31:0] rdata
);

    int delay;

    assign rdata = req_addr ^ KEY;  // data is a fixed function of the address.

    // ready comes 0 to 3 cycles after a word is asked for.
    initial
    begin
        ready = 1'b0;
        delay = 0;
        forever
        begin
            @(posedge clk);
            #2;
            if (rst)
            begin
                ready = 1'b0;
                delay = int'($urandom % 4);
            end
            else if (ready)
            begin
                delay = int'($urandom % 4);  // a word was taken, draw the next gap.
                ready = req_valid && (delay == 0);
                if (delay != 0)
                    delay = delay - 1;
            end
            else if (req_valid)
            begin
                if (delay == 0)
                    ready = 1'b1;
                else
                    delay = delay - 1;
            end
        end
    end

endmodule

//--- testbench/tb_ifetch.sv
`timescale 1ns/1ps

module tb_ifetch
    import icache_pkg::*;
();

    localparam addr_t RESET_PC   = 32'h0000_0100;
    localparam addr_t MEM_FN_KEY = 32'h5a3c_96e1;
    localparam addr_t LOOP_BASE  = 32'h0000_0400;
    localparam addr_t REVISIT    = LOOP_BASE + 32'h60;  // index 6 is untouched after the loop.
    localparam int    SEED       = 13975;

    logic        clk;
    logic        rst;
    logic        redirect_valid;
    addr_t       redirect_pc;
    logic        flush;
    logic        inst_valid;
    fetch_resp_t inst_data;
    logic        inst_ready;
    logic        mem_req_valid;
    addr_t       mem_req_addr;
    logic        mem_ready;
    addr_t       mem_rdata;

    addr_t       exp_pc;
    int          accepted;
    int          bursts;
    logic [1:0]  mem_beat;
    addr_t       mem_base;
    logic [15:0] line_valid;
    logic [23:0] line_tag [16];
    logic        hit_only;  // no memory traffic allowed while set.
    logic        fire;
    logic        xfer;

    ifetch_top #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .flush(flush),
        .inst_valid(inst_valid),
        .inst_data(inst_data),
        .inst_ready(inst_ready),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    mem_model #(
        .KEY(MEM_FN_KEY)
    ) u_mem (
        .clk(clk),
        .rst(rst),
        .req_valid(mem_req_valid),
        .req_addr(mem_req_addr),
        .ready(mem_ready),
        .rdata(mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign fire = inst_valid && inst_ready;
    assign xfer = mem_req_valid && mem_ready;

    // reference model of the PC and of which lines the cache holds.
    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_pc     <= RESET_PC;
            accepted   <= 0;
            bursts     <= 0;
            mem_beat   <= 2'd0;
            line_valid <= '0;
        end
        else
        begin
            if (redirect_valid)
                exp_pc <= redirect_pc;
            else if (fire)
                exp_pc <= exp_pc + 32'd4;
            if (fire)
                accepted <= accepted + 1;
            if (flush)
                line_valid <= '0;  // only pulsed while the cache is idle.
            if (xfer)
            begin
                mem_beat <= mem_beat + 2'd1;
                if (mem_beat == 2'd0)
                begin
                    mem_base <= mem_req_addr;
                    bursts   <= bursts + 1;
                end
                if (mem_beat == 2'd3)
                begin
                    line_valid[mem_base[7:4]] <= 1'b1;
                    line_tag[mem_base[7:4]]   <= mem_base[31:8];
                end
            end
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    assert property (@(posedge clk) disable iff (rst) fire |-> inst_data.addr == exp_pc)
    else
        stop_run($sformatf("Mismatch at %0t: inst addr %h, expected %h",
                           $time, $sampled(inst_data.addr), $sampled(exp_pc)));

    assert property (@(posedge clk) disable iff (rst)
        fire |-> inst_data.inst == (exp_pc ^ MEM_FN_KEY))
    else
        stop_run($sformatf("Mismatch at %0t: inst %h, expected %h", $time,
                           $sampled(inst_data.inst), $sampled(exp_pc) ^ MEM_FN_KEY));

    assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready && !redirect_valid |=> inst_valid && $stable(inst_data))
    else
        stop_run($sformatf("Mismatch at %0t: held instruction changed or dropped", $time));

    assert property (@(posedge clk) disable iff (rst)
        xfer && mem_beat == 2'd0 |-> mem_req_addr[3:0] == 4'h0)
    else
        stop_run($sformatf("Mismatch at %0t: refill starts at %h, not a line base",
                           $time, $sampled(mem_req_addr)));

    assert property (@(posedge clk) disable iff (rst)
        xfer && mem_beat != 2'd0 |-> mem_req_addr == mem_base + {28'd0, mem_beat, 2'b00})
    else
        stop_run($sformatf("Mismatch at %0t: refill word addr %h, line base %h",
                           $time, $sampled(mem_req_addr), $sampled(mem_base)));

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !(mem_ready && mem_beat == 2'd3) |=> mem_req_valid)
    else
        stop_run("memory request dropped before all four words of the line");

    assert property (@(posedge clk) disable iff (rst)
        xfer && mem_beat == 2'd3 |=> !mem_req_valid)
    else
        stop_run("memory request went on after the fourth word of the line");

    assert property (@(posedge clk) disable iff (rst)
        xfer && mem_beat == 2'd0 |->
            !(line_valid[mem_req_addr[7:4]] && line_tag[mem_req_addr[7:4]] == mem_req_addr[31:8]))
    else
        stop_run("refill started for a line that the cache already holds");

    assert property (@(posedge clk) disable iff (rst) hit_only |-> !mem_req_valid)
    else
        stop_run("memory was read during a pass where every line should hit");

    // takes n more instructions and stops with inst_ready low.
    task automatic accept_insts(input int n, input bit random_ready);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        inst_ready = !random_ready || ($urandom % 3 != 0);
        while (accepted < target && cycles < 200 + 40 * n)
        begin
            @(posedge clk);
            #2;
            cycles++;
            if (accepted < target)
                inst_ready = !random_ready || ($urandom % 3 != 0);
        end
        inst_ready = 1'b0;
        if (accepted < target)
            stop_run("timeout waiting for instructions from the fetch unit");
    endtask

    // stalls the consumer until the output is full and memory is quiet.
    task automatic drain();
        int quiet;
        int cycles;
        inst_ready = 1'b0;
        quiet = 0;
        cycles = 0;
        while (quiet < 10 && cycles < 500)
        begin
            @(posedge clk);
            #2;
            cycles++;
            if (inst_valid && !mem_req_valid)
                quiet++;
            else
                quiet = 0;
        end
        if (quiet < 10)
            stop_run("timeout waiting for the fetch pipeline to settle");
    endtask

    task automatic redirect_to(input addr_t pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk);
        #2;
        redirect_valid = 1'b0;
    endtask

    // redirects to base and waits for the refill of that line.
    task automatic expect_refill(input addr_t base);
        int start;
        int cycles;
        start = bursts;
        cycles = 0;
        redirect_to(base);
        while (bursts == start && cycles < 100)
        begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (bursts == start)
            stop_run("timeout waiting for a refill after the flush");
        else
            assert (mem_base == base)
            else
                stop_run($sformatf("Mismatch at %0t: refill of %h, expected %h",
                                   $time, mem_base, base));
    endtask

    initial
    begin
        void'($urandom(SEED));
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        flush          = 1'b0;
        inst_ready     = 1'b0;
        hit_only       = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        accept_insts(24, 1'b0);  // cold misses from the reset PC.

        // 8-line loop whose second pass must hit everywhere.
        drain();
        redirect_to(LOOP_BASE);
        accept_insts(32, 1'b1);
        drain();
        hit_only = 1'b1;
        redirect_to(LOOP_BASE);
        accept_insts(32, 1'b1);
        drain();
        hit_only = 1'b0;

        accept_insts(6, 1'b1);
        inst_ready = ($urandom % 2 == 0);
        redirect_to(32'h0000_2008);  // mid-line target.
        accept_insts(12, 1'b1);
        inst_ready = 1'b1;
        redirect_to(RESET_PC + 32'd20);
        accept_insts(12, 1'b1);

        drain();
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        expect_refill(REVISIT);
        accept_insts(8, 1'b1);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb.f
hdl/icache_pkg.sv
hdl/icache_arrays.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/fetch_unit.sv
hdl/ifetch_top.sv
testbench/mem_model.sv
testbench/tb_ifetch.sv

//--- Makefile
# Verilator build and run of the instruction fetch testbench.

.PHONY: run clean

run: obj_dir/Vtb_ifetch
	@out="$$(./obj_dir/Vtb_ifetch)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

obj_dir/Vtb_ifetch: tb.f $(wildcard hdl/*.sv testbench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ifetch -f tb.f

clean:
	rm -rf obj_dir
